/* hw/dcache_pkg.sv */
package dcache_pkg;

    // address split is tag | index | word offset | byte alignment
    localparam int tag_bits = 24;
    localparam int idx_bits = 3;
    localparam int num_sets = 8;
    localparam int line_bytes = 32;
    localparam int offset_bits = 3;

    typedef logic [tag_bits-1:0] tag_t;

    typedef logic [idx_bits-1:0] idx_t;

    typedef logic [31:0] word_t;

    // byte k of a line sits at bits 8k+7 down to 8k
    typedef logic [8*line_bytes-1:0] line_t;

endpackage

/* hw/cache_array.sv */
`timescale 1ns/1ps

module cache_array #(
    parameter type entry_type = logic
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              write,
    input  dcache_pkg::idx_t  index,
    input  entry_type         datain,
    output entry_type         dataout
);

    entry_type entries [dcache_pkg::num_sets];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dcache_pkg::num_sets; i++) begin
                entries[i] <= entry_type'(0);
            end
        end else if (write) begin
            entries[index] <= datain;
        end
    end

    // read is combinational so a hit resolves in the same cycle
    assign dataout = entries[index];

endmodule

/* hw/lane_align.sv */
`timescale 1ns/1ps

module lane_align (
    input  dcache_pkg::word_t word_in,
    input  dcache_pkg::word_t write_word,
    input  logic [1:0]        alignment,
    input  logic [3:0]        byte_enable,
    output dcache_pkg::word_t read_word,
    output dcache_pkg::word_t merged_word
);

    // shift the addressed byte down to lane 0, zeros come in from the top
    assign read_word = word_in >> {alignment, 3'b000};

    // write lanes move up by the alignment, lanes below it keep old data
    always_comb begin
        int src;
        merged_word = word_in;
        for (int k = 0; k < 4; k++) begin
            src = k - int'(alignment);
            if (src >= 0) begin
                if (byte_enable[src]) begin
                    merged_word[8*k +: 8] = write_word[8*src +: 8];
                end
            end
        end
    end

endmodule

/* hw/dcache_datapath.sv */
`timescale 1ns/1ps

module dcache_datapath (
    input  logic              clk,
    input  logic              rst,
    // cpu side
    input  logic [31:0]       mem_address,
    input  dcache_pkg::word_t mem_wdata,
    input  logic [3:0]        mem_byte_enable,
    output dcache_pkg::word_t mem_rdata,
    // memory side
    input  dcache_pkg::line_t pmem_rdata,
    output logic [31:0]       pmem_address,
    output dcache_pkg::line_t pmem_wdata,
    // from control
    input  logic              way_sel_method,
    input  logic              load_line_data,
    input  logic              load_valid,
    input  logic              load_dirty,
    input  logic              load_lru,
    input  logic              load_wb_reg,
    input  logic              line_datain_sel,
    input  logic              valid_in,
    input  logic              dirty_in,
    input  logic              address_sel,
    // to control
    output logic              hit,
    output logic              valid,
    output logic              dirty
);

    dcache_pkg::tag_t                      tag;
    dcache_pkg::idx_t                      idx;
    logic [dcache_pkg::offset_bits-1:0]    offset;
    logic [1:0]                            alignment;

    assign tag       = mem_address[31 -: dcache_pkg::tag_bits];
    assign idx       = mem_address[dcache_pkg::offset_bits+2 +: dcache_pkg::idx_bits];
    assign offset    = mem_address[2 +: dcache_pkg::offset_bits];
    assign alignment = mem_address[1:0];

    dcache_pkg::line_t line_out [2];
    dcache_pkg::tag_t  tag_out [2];
    logic              valid_out [2];
    logic              dirty_out [2];
    logic [1:0]        hit_way;
    logic [1:0]        load_data_way;
    logic [1:0]        load_valid_way;
    logic [1:0]        load_dirty_way;
    logic              way_select;
    logic              lru_out;
    dcache_pkg::line_t line_datain;

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign load_data_way[w]  = load_line_data && (way_select == 1'(w));
        assign load_valid_way[w] = load_valid && (way_select == 1'(w));
        assign load_dirty_way[w] = load_dirty && (way_select == 1'(w));

        cache_array #(.entry_type(dcache_pkg::line_t)) data_array (
            .clk,
            .rst,
            .write   (load_data_way[w]),
            .index   (idx),
            .datain  (line_datain),
            .dataout (line_out[w])
        );

        // tag goes in with the line, on fill and on write hit alike
        cache_array #(.entry_type(dcache_pkg::tag_t)) tag_array (
            .clk,
            .rst,
            .write   (load_data_way[w]),
            .index   (idx),
            .datain  (tag),
            .dataout (tag_out[w])
        );

        cache_array #(.entry_type(logic)) valid_array (
            .clk,
            .rst,
            .write   (load_valid_way[w]),
            .index   (idx),
            .datain  (valid_in),
            .dataout (valid_out[w])
        );

        cache_array #(.entry_type(logic)) dirty_array (
            .clk,
            .rst,
            .write   (load_dirty_way[w]),
            .index   (idx),
            .datain  (dirty_in),
            .dataout (dirty_out[w])
        );

        assign hit_way[w] = valid_out[w] && (tag_out[w] == tag);
    end

    // lru bit names the way to evict next
    cache_array #(.entry_type(logic)) lru_array (
        .clk,
        .rst,
        .write   (load_lru),
        .index   (idx),
        .datain  (~way_select),
        .dataout (lru_out)
    );

    assign hit        = |hit_way;
    assign way_select = way_sel_method ? lru_out : hit_way[1];
    assign valid      = valid_out[way_select];
    assign dirty      = dirty_out[lru_out];

    dcache_pkg::line_t selected_line;
    dcache_pkg::line_t modified_line;
    dcache_pkg::word_t selected_word;
    dcache_pkg::word_t merged_word;

    assign selected_line = line_out[way_select];
    assign selected_word = selected_line[32*offset +: 32];

    lane_align aligner (
        .word_in     (selected_word),
        .write_word  (mem_wdata),
        .alignment   (alignment),
        .byte_enable (mem_byte_enable),
        .read_word   (mem_rdata),
        .merged_word (merged_word)
    );

    // splice the merged word back into its slot
    always_comb begin
        modified_line = selected_line;
        for (int i = 0; i < dcache_pkg::line_bytes / 4; i++) begin
            if (offset == i[dcache_pkg::offset_bits-1:0]) begin
                modified_line[32*i +: 32] = merged_word;
            end
        end
    end

    assign line_datain = line_datain_sel ? modified_line : pmem_rdata;

    // victim line held stable for the whole write-back
    dcache_pkg::line_t wb_line;

    always_ff @(posedge clk) begin
        if (load_wb_reg) begin
            wb_line <= line_out[lru_out];
        end
    end

    assign pmem_wdata = wb_line;

    logic [31:0] wb_address;

    assign wb_address   = {tag_out[lru_out], idx, 5'b00000};
    assign pmem_address = address_sel ? wb_address : {mem_address[31:5], 5'b00000};

endmodule

/* hw/dcache_control.sv */
`timescale 1ns/1ps

module dcache_control (
    input  logic clk,
    input  logic rst,
    input  logic mem_read,
    input  logic mem_write,
    input  logic pmem_resp,
    input  logic hit,
    input  logic valid,
    input  logic dirty,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write,
    output logic way_sel_method,
    output logic load_line_data,
    output logic load_valid,
    output logic load_dirty,
    output logic load_lru,
    output logic load_wb_reg,
    output logic line_datain_sel,
    output logic valid_in,
    output logic dirty_in,
    output logic address_sel
);

    typedef enum logic [1:0] {
        st_check,
        st_write_back,
        st_fill
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_check;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state      = state;
        mem_resp        = 1'b0;
        pmem_read       = 1'b0;
        pmem_write      = 1'b0;
        way_sel_method  = 1'b0;
        load_line_data  = 1'b0;
        load_valid      = 1'b0;
        load_dirty      = 1'b0;
        load_lru        = 1'b0;
        load_wb_reg     = 1'b0;
        line_datain_sel = 1'b0;
        valid_in        = 1'b0;
        dirty_in        = 1'b0;
        address_sel     = 1'b0;

        unique case (state)
            st_check: begin
                if (mem_read || mem_write) begin
                    if (hit) begin
                        mem_resp = 1'b1;
                        load_lru = 1'b1;
                        if (mem_write) begin
                            load_line_data  = 1'b1;
                            line_datain_sel = 1'b1;
                            load_dirty      = 1'b1;
                            dirty_in        = 1'b1;
                        end
                    end else begin
                        // miss goes to the lru way, grab it before it is replaced
                        way_sel_method = 1'b1;
                        load_wb_reg    = 1'b1;
                        if (valid && dirty) begin
                            next_state = st_write_back;
                        end else begin
                            next_state = st_fill;
                        end
                    end
                end
            end

            st_write_back: begin
                way_sel_method = 1'b1;
                address_sel    = 1'b1;
                pmem_write     = 1'b1;
                if (pmem_resp) begin
                    next_state = st_fill;
                end
            end

            st_fill: begin
                way_sel_method = 1'b1;
                pmem_read      = 1'b1;
                if (pmem_resp) begin
                    load_line_data = 1'b1;
                    load_valid     = 1'b1;
                    valid_in       = 1'b1;
                    load_dirty     = 1'b1;
                    next_state     = st_check;
                end
            end

            default: begin
                next_state = st_check;
            end
        endcase
    end

endmodule

/* hw/dcache.sv */
`timescale 1ns/1ps

module dcache (
    input  logic              clk,
    input  logic              rst,
    // cpu side
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic [31:0]       mem_address,
    input  dcache_pkg::word_t mem_wdata,
    input  logic [3:0]        mem_byte_enable,
    output dcache_pkg::word_t mem_rdata,
    output logic              mem_resp,
    // memory side
    input  dcache_pkg::line_t pmem_rdata,
    input  logic              pmem_resp,
    output logic              pmem_read,
    output logic              pmem_write,
    output logic [31:0]       pmem_address,
    output dcache_pkg::line_t pmem_wdata
);

    logic way_sel_method;
    logic load_line_data;
    logic load_valid;
    logic load_dirty;
    logic load_lru;
    logic load_wb_reg;
    logic line_datain_sel;
    logic valid_in;
    logic dirty_in;
    logic address_sel;
    logic hit;
    logic valid;
    logic dirty;

    dcache_control control (
        .clk,
        .rst,
        .mem_read,
        .mem_write,
        .pmem_resp,
        .hit,
        .valid,
        .dirty,
        .mem_resp,
        .pmem_read,
        .pmem_write,
        .way_sel_method,
        .load_line_data,
        .load_valid,
        .load_dirty,
        .load_lru,
        .load_wb_reg,
        .line_datain_sel,
        .valid_in,
        .dirty_in,
        .address_sel
    );

    dcache_datapath datapath (
        .clk,
        .rst,
        .mem_address,
        .mem_wdata,
        .mem_byte_enable,
        .mem_rdata,
        .pmem_rdata,
        .pmem_address,
        .pmem_wdata,
        .way_sel_method,
        .load_line_data,
        .load_valid,
        .load_dirty,
        .load_lru,
        .load_wb_reg,
        .line_datain_sel,
        .valid_in,
        .dirty_in,
        .address_sel,
        .hit,
        .valid,
        .dirty
    );

endmodule

/* tests/pmem_model.sv */
`timescale 1ns/1ps

module pmem_model #(
    parameter logic [31:0] seed_init = 32'h1
) (
    input  logic              clk,
    input  logic              pmem_read,
    input  logic              pmem_write,
    input  logic [31:0]       pmem_address,
    input  dcache_pkg::line_t pmem_wdata,
    output dcache_pkg::line_t pmem_rdata,
    output logic              pmem_resp
);

    // 64 lines of 32 bytes, addresses 0 to 2047
    dcache_pkg::line_t lines [64];

    int                seed;
    int                countdown;
    logic              busy;
    int                read_count;
    int                write_count;
    int                bad_count;
    logic [31:0]       last_write_addr;
    dcache_pkg::line_t last_write_data;

    initial begin
        seed            = seed_init;
        countdown       = 0;
        busy            = 1'b0;
        read_count      = 0;
        write_count     = 0;
        bad_count       = 0;
        last_write_addr = '0;
        last_write_data = '0;
        pmem_resp       = 1'b0;
        pmem_rdata      = '0;
    end

    // outputs change on the falling edge, the cache samples on the rising one
    always @(negedge clk) begin
        if (pmem_resp) begin
            pmem_resp = 1'b0;
        end else if (pmem_read || pmem_write) begin
            if (!busy) begin
                busy      = 1'b1;
                countdown = $unsigned($random(seed)) % 4;
            end
            if (countdown > 0) begin
                countdown--;
            end else begin
                busy = 1'b0;
                if (pmem_address[4:0] != 5'd0 || pmem_address[31:11] != '0 ||
                    (pmem_read && pmem_write)) begin
                    bad_count++;
                    $display("ERROR t=%0t memory request is not a single aligned line access: %h",
                             $time, pmem_address);
                end
                if (pmem_write) begin
                    lines[pmem_address[10:5]] = pmem_wdata;
                    write_count++;
                    last_write_addr = pmem_address;
                    last_write_data = pmem_wdata;
                end else begin
                    pmem_rdata = lines[pmem_address[10:5]];
                    read_count++;
                end
                pmem_resp = 1'b1;
            end
        end
    end

endmodule

/* tests/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

    localparam logic [31:0] seed_value   = 32'h84e9_28f1;
    localparam int          resp_timeout = 200;
    localparam int          mix_ops      = 400;

    logic              clk;
    logic              rst;
    logic              mem_read;
    logic              mem_write;
    logic [31:0]       mem_address;
    dcache_pkg::word_t mem_wdata;
    logic [3:0]        mem_byte_enable;
    dcache_pkg::word_t mem_rdata;
    logic              mem_resp;
    dcache_pkg::line_t pmem_rdata;
    logic              pmem_resp;
    logic              pmem_read;
    logic              pmem_write;
    logic [31:0]       pmem_address;
    dcache_pkg::line_t pmem_wdata;

    int         seed;
    int         errors;
    logic       timed_out;
    logic [7:0] ref_mem [2048];

    dcache dut (
        .clk,
        .rst,
        .mem_read,
        .mem_write,
        .mem_address,
        .mem_wdata,
        .mem_byte_enable,
        .mem_rdata,
        .mem_resp,
        .pmem_rdata,
        .pmem_resp,
        .pmem_read,
        .pmem_write,
        .pmem_address,
        .pmem_wdata
    );

    pmem_model #(.seed_init(seed_value)) pmem (
        .clk,
        .pmem_read,
        .pmem_write,
        .pmem_address,
        .pmem_wdata,
        .pmem_rdata,
        .pmem_resp
    );

    initial clk = 1'b0;

    always #10 clk = ~clk;

    // test addresses stay below 2 KiB, tag values 0 to 7
    function automatic logic [31:0] make_addr(input int tag, input int set, input int word,
                                              input int align);
        return {21'b0, tag[2:0], set[2:0], word[2:0], align[1:0]};
    endfunction

    function automatic int draw(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic dcache_pkg::word_t expected_read(input logic [31:0] addr);
        int                base;
        dcache_pkg::word_t w;
        base = {addr[10:2], 2'b00};
        w = {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
        return w >> (8 * addr[1:0]);
    endfunction

    // byte k of the word takes write byte k minus alignment
    function automatic void apply_write(input logic [31:0] addr, input dcache_pkg::word_t wdata,
                                        input logic [3:0] be);
        int base;
        int src;
        base = {addr[10:2], 2'b00};
        for (int k = 0; k < 4; k++) begin
            src = k - int'(addr[1:0]);
            if (src >= 0) begin
                if (be[src]) begin
                    ref_mem[base+k] = wdata[8*src +: 8];
                end
            end
        end
    endfunction

    function automatic dcache_pkg::line_t ref_line(input int l);
        dcache_pkg::line_t line;
        for (int b = 0; b < 32; b++) begin
            line[8*b +: 8] = ref_mem[32*l + b];
        end
        return line;
    endfunction

    task automatic compare(input string name, input logic [255:0] actual,
                           input logic [255:0] expected);
        if (!timed_out && actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic finish_run;
        $display("errors: %0d check failures, %0d memory protocol errors",
                 errors, pmem.bad_count);
        if (errors == 0 && pmem.bad_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // entered and left on a falling edge
    task automatic access(input logic wr, input logic [31:0] addr, input dcache_pkg::word_t wdata,
                          input logic [3:0] be, output int n_reads, output int n_writes);
        int                reads_start;
        int                writes_start;
        int                cycles;
        logic              got;
        dcache_pkg::word_t rdata;
        dcache_pkg::word_t expected;
        n_reads  = 0;
        n_writes = 0;
        if (timed_out) begin
            return;
        end
        reads_start     = pmem.read_count;
        writes_start    = pmem.write_count;
        expected        = expected_read(addr);
        mem_read        = ~wr;
        mem_write       = wr;
        mem_address     = addr;
        mem_wdata       = wdata;
        mem_byte_enable = be;
        got             = 1'b0;
        cycles          = 0;
        rdata           = '0;
        while (!got && cycles < resp_timeout) begin
            @(posedge clk);
            cycles++;
            if (mem_resp === 1'b1) begin
                got   = 1'b1;
                rdata = mem_rdata;
            end
        end
        if (!got) begin
            errors++;
            timed_out = 1'b1;
            $display("ERROR t=%0t cache gave no mem_resp within %0d cycles for address %h",
                     $time, resp_timeout, addr);
        end else begin
            n_reads  = pmem.read_count - reads_start;
            n_writes = pmem.write_count - writes_start;
            if (wr) begin
                apply_write(addr, wdata, be);
            end else begin
                compare("mem_rdata", rdata, expected);
            end
            @(negedge clk);
            mem_read  = 1'b0;
            mem_write = 1'b0;
        end
    endtask

    initial begin
        dcache_pkg::line_t line;
        dcache_pkg::word_t w;
        logic [31:0]       addr;
        int                nr;
        int                nw;

        seed            = seed_value;
        errors          = 0;
        timed_out       = 1'b0;
        rst             = 1'b1;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_address     = '0;
        mem_wdata       = '0;
        mem_byte_enable = '0;

        // same random words go to the backing store and the reference
        for (int l = 0; l < 64; l++) begin
            for (int i = 0; i < 8; i++) begin
                w = $random(seed);
                line[32*i +: 32] = w;
                for (int b = 0; b < 4; b++) begin
                    ref_mem[32*l + 4*i + b] = w[8*b +: 8];
                end
            end
            pmem.lines[l] = line;
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // cold read miss
        addr = make_addr(0, 0, draw(8), draw(4));
        access(1'b0, addr, '0, '0, nr, nw);
        compare("pmem_read count", nr, 1);
        compare("pmem_write count", nw, 0);

        // repeated read hits
        access(1'b0, addr, '0, '0, nr, nw);
        compare("pmem_read count", nr, 0);
        compare("pmem_write count", nw, 0);

        // write allocate, write hit, read back
        addr = make_addr(4, 1, draw(8), draw(4));
        access(1'b1, addr, $random(seed), draw(16), nr, nw);
        compare("pmem_read count", nr, 1);
        access(1'b1, addr, $random(seed), draw(16), nr, nw);
        compare("pmem_read count", nr, 0);
        compare("pmem_write count", nw, 0);
        access(1'b0, addr, '0, '0, nr, nw);
        compare("pmem_read count", nr, 0);

        // lru in set 5 with tags 1, 2, 3
        access(1'b0, make_addr(1, 5, 0, 0), '0, '0, nr, nw);
        access(1'b0, make_addr(2, 5, 1, 0), '0, '0, nr, nw);
        access(1'b0, make_addr(1, 5, 2, 1), '0, '0, nr, nw);
        compare("pmem_read count", nr, 0);
        access(1'b0, make_addr(3, 5, 3, 2), '0, '0, nr, nw);
        compare("pmem_read count", nr, 1);
        compare("pmem_write count", nw, 0);
        access(1'b0, make_addr(1, 5, 4, 3), '0, '0, nr, nw);
        compare("pmem_read count", nr, 0);
        compare("pmem_write count", nw, 0);
        access(1'b0, make_addr(2, 5, 5, 0), '0, '0, nr, nw);
        compare("pmem_read count", nr, 1);

        // dirty victim in set 6, then a clean one
        addr = make_addr(1, 6, draw(8), draw(4));
        access(1'b1, addr, $random(seed), 4'hf, nr, nw);
        compare("pmem_write count", nw, 0);
        access(1'b0, make_addr(2, 6, 0, 0), '0, '0, nr, nw);
        compare("pmem_write count", nw, 0);
        access(1'b0, make_addr(3, 6, 0, 0), '0, '0, nr, nw);
        compare("pmem_write count", nw, 1);
        compare("pmem_address", pmem.last_write_addr, make_addr(1, 6, 0, 0));
        compare("pmem_wdata", pmem.last_write_data, ref_line(addr[10:5]));
        access(1'b0, addr, '0, '0, nr, nw);
        compare("pmem_read count", nr, 1);
        compare("pmem_write count", nw, 0);

        for (int n = 0; n < mix_ops; n++) begin
            addr = make_addr(draw(6), draw(4), draw(8), draw(4));
            if (draw(2) == 1) begin
                access(1'b1, addr, $random(seed), draw(16), nr, nw);
            end else begin
                access(1'b0, addr, '0, '0, nr, nw);
            end
        end

        // read every mixed line back, then push both ways of sets 0 to 3 out
        for (int t = 0; t < 6; t++) begin
            for (int s = 0; s < 4; s++) begin
                for (int i = 0; i < 8; i++) begin
                    access(1'b0, make_addr(t, s, i, 0), '0, '0, nr, nw);
                end
            end
        end
        for (int s = 0; s < 4; s++) begin
            access(1'b0, make_addr(6, s, 0, 0), '0, '0, nr, nw);
            access(1'b0, make_addr(7, s, 0, 0), '0, '0, nr, nw);
        end
        for (int l = 0; l < 64; l++) begin
            compare($sformatf("pmem line %0d", l), pmem.lines[l], ref_line(l));
        end

        finish_run();
    end

endmodule

/* files.f */
hw/dcache_pkg.sv
hw/cache_array.sv
hw/lane_align.sv
hw/dcache_datapath.sv
hw/dcache_control.sv
hw/dcache.sv
tests/pmem_model.sv
tests/dcache_tb.sv
